//--- Makefile
SIM := obj_dir/Vtrigger_links_tb

$(SIM): trigger_links.f $(wildcard design/*.sv design/*.svh tb/*.sv)
	verilator --binary --timing --assert -Wno-fatal -f trigger_links.f --top-module trigger_links_tb

run: $(SIM)
	./$(SIM) | awk '{ print } /^Testbench passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: run clean

//--- design/cluster_validator.sv
`timescale 1ns/10ps
`include "trigger_link_consts.svh"

module cluster_validator
  import trigger_link_pkg::*;
(
  input  logic                       clk_40,
  input  logic                       reset,
  input  logic                       bx_strobe,
  input  cluster_t [`N_CLUSTERS-1:0] clusters,
  input  logic [11:0]                bxn,
  input  logic                       bc0,
  input  logic                       overflow,
  output bx_sample_t                 sample,
  output logic                       sample_strobe,
  output logic [`N_CLUSTERS-1:0]     valid_clusters,
  output logic                       valid_clusters_or
);

  localparam int HOLD_W = $clog2(`FRAME_WORDS);
  localparam logic [HOLD_W-1:0] HOLDOFF_START = HOLD_W'(`FRAME_WORDS - 1);

  logic [HOLD_W-1:0]      holdoff;     // Cycles left before next strobe is taken
  logic                   accept;      // Strobe that starts a new sample
  logic [`N_CLUSTERS-1:0] valid_next;

  assign accept = bx_strobe && (holdoff == '0);

  always_comb begin
    for (int i = 0; i < `N_CLUSTERS; i++) begin
      valid_next[i] = (clusters[i].addr[10:9] != 2'b11);  // 11 marks an empty slot
    end
  end

  // ------------------------------
  // Control
  // ------------------------------
  always_ff @(posedge clk_40) begin
    if (reset) begin
      holdoff        <= '0;
      sample_strobe  <= 1'b0;
      valid_clusters <= '0;
    end else begin
      sample_strobe <= accept;
      if (accept) begin
        holdoff        <= HOLDOFF_START;
        valid_clusters <= valid_next;
      end else if (holdoff != '0) begin
        holdoff <= holdoff - 1'b1;
      end
    end
  end

  // Sample holds until the next accepted strobe
  always_ff @(posedge clk_40) begin
    if (accept) begin
      sample <= '{clusters: clusters, bxn: bxn, bc0: bc0, overflow: overflow};
    end
  end

  assign valid_clusters_or = |valid_clusters;

  // Strobes inside one frame time are dropped by the holdoff
  strobe_spacing_a: assert property (
    @(posedge clk_40) disable iff (reset)
    bx_strobe |=> !bx_strobe [*(`FRAME_WORDS - 1)]
  ) else $warning("bx_strobe closer than %0d cycles, strobe dropped", `FRAME_WORDS);

endmodule

//--- design/link_framer.sv
`timescale 1ns/10ps
`include "trigger_link_consts.svh"

module link_framer
  import trigger_link_pkg::*;
(
  input  logic          clk_40,
  input  logic          reset,
  input  logic          link_ready,
  input  logic          sample_strobe,
  input  frame_header_t header,
  input  link_payload_t payload,
  output link_word_t    tx_word
);

  localparam int CNT_W = $clog2(`FRAME_WORDS);
  localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(`FRAME_WORDS - 1);

  frame_header_t    header_q;
  link_payload_t    payload_q;
  logic [7:0]       crc_q;
  logic [CNT_W-1:0] word_cnt;   // Word being sent
  logic             in_frame;
  logic             start;      // Frame begins next cycle

  // ------------------------------
  // CRC-8 over header and payload
  // ------------------------------
  function automatic logic [7:0] crc8(input logic [63:0] data);
    logic [7:0] crc;
    logic       fb;
    crc = 8'h00;
    for (int i = 63; i >= 0; i--) begin
      fb  = crc[7] ^ data[i];
      crc = {crc[6:0], 1'b0};
      if (fb) begin
        crc = crc ^ `CRC8_POLY;
      end
    end
    return crc;
  endfunction

  // A new frame may follow word 4 directly
  assign start = sample_strobe && link_ready && (!in_frame || word_cnt == LAST_WORD);

  // ------------------------------
  // Word sequencing
  // ------------------------------
  always_ff @(posedge clk_40) begin
    if (reset) begin
      in_frame <= 1'b0;
      word_cnt <= '0;
    end else if (start) begin
      in_frame <= 1'b1;
      word_cnt <= '0;
    end else if (in_frame) begin
      if (word_cnt == LAST_WORD) begin
        in_frame <= 1'b0;
        word_cnt <= '0;
      end else begin
        word_cnt <= word_cnt + 1'b1;
      end
    end
  end

  // Frame contents, held for the whole frame
  always_ff @(posedge clk_40) begin
    if (start) begin
      header_q  <= header;
      payload_q <= payload;
      crc_q     <= crc8({header, payload});
    end
  end

  // ------------------------------
  // Output mux
  // ------------------------------
  always_comb begin
    tx_word.is_k = 1'b0;
    case (word_cnt)
      0:       tx_word.data = {`COMMA_BYTE, header_q};    // Comma marks frame start
      1:       tx_word.data = payload_q[55:40];
      2:       tx_word.data = payload_q[39:24];
      3:       tx_word.data = payload_q[23:8];
      default: tx_word.data = {payload_q[7:0], crc_q};
    endcase
    if (!in_frame) begin
      tx_word.data = {`COMMA_BYTE, `IDLE_BYTE};
      tx_word.is_k = 1'b1;
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // Link stays silent until the sequencer releases it
  idle_before_ready_a: assert property (
    @(posedge clk_40) disable iff (reset)
    !link_ready |-> tx_word.is_k
  ) else $error("frame sent before link_ready");

endmodule

//--- design/trigger_link_consts.svh
`ifndef TRIGGER_LINK_CONSTS_SVH
`define TRIGGER_LINK_CONSTS_SVH

// ------------------------------
// Link geometry
// ------------------------------
`define N_CLUSTERS        8     // Clusters per BX
`define CLUSTERS_PER_LINK 4     // Clusters in one link frame
`define N_LINKS           4     // CSC right/left, GEM right/left
`define FRAME_WORDS       5     // Words per frame, also min strobe spacing

// ------------------------------
// Line coding
// ------------------------------
`define COMMA_BYTE        8'hBC // Marks word 0 and the idle word
`define IDLE_BYTE         8'h50 // Low byte of the idle word

// ------------------------------
// Reset and protection
// ------------------------------
`define RESET_HOLD_CYCLES 15    // Silent cycles after reset
`define CRC8_POLY         8'h07 // x^8 + x^2 + x + 1, init 0, MSB first

`endif

//--- design/trigger_link_pkg.sv
`include "trigger_link_consts.svh"

package trigger_link_pkg;

  // ------------------------------
  // Cluster and BX sample
  // ------------------------------

  // Invalid when addr[10:9] == 2'b11
  typedef struct packed {
    logic [2:0]  size;     // Cluster size
    logic [10:0] addr;     // Pad address
  } cluster_t;

  typedef struct packed {
    cluster_t [`N_CLUSTERS-1:0] clusters; // Cluster 0 in lowest bits
    logic [11:0]                bxn;      // Bunch crossing number
    logic                       bc0;      // Orbit marker
    logic                       overflow; // More clusters than slots
  } bx_sample_t;

  // ------------------------------
  // Link frame pieces
  // ------------------------------

  // One group of clusters for one link, cluster 0 of the group lowest
  typedef struct packed {
    cluster_t [`CLUSTERS_PER_LINK-1:0] clusters;
  } link_payload_t;

  typedef struct packed {
    logic       bc0;       // Bit 7
    logic       overflow;  // Bit 6
    logic [5:0] bxn;       // Low BX bits
  } frame_header_t;

  // Word toward the serializer
  typedef struct packed {
    logic [15:0] data;
    logic        is_k;     // Set on idle words
  } link_word_t;

endpackage

//--- design/trigger_links.sv
`timescale 1ns/10ps
`include "trigger_link_consts.svh"

module trigger_links
  import trigger_link_pkg::*;
(
  input  logic                         clk_40,
  input  logic                         reset,
  input  cluster_t [`N_CLUSTERS-1:0]   clusters,
  input  logic [11:0]                  bxn,
  input  logic                         bc0,
  input  logic                         overflow,
  input  logic                         bx_strobe,
  output logic [`N_CLUSTERS-1:0]       valid_clusters,
  output logic                         valid_clusters_or,
  output logic                         link_ready,
  output link_word_t [`N_LINKS-1:0]    tx_words
);

  bx_sample_t                   sample;
  logic                         sample_strobe;
  link_payload_t                payload_right;  // Clusters 0 to 3
  link_payload_t                payload_left;   // Clusters 4 to 7
  frame_header_t                header;
  link_payload_t [`N_LINKS-1:0] link_payloads;

  // ------------------------------
  // Reset hold and input sampling
  // ------------------------------
  tx_reset_sequencer reset_seq_i (
    .clk_40     (clk_40),
    .reset      (reset),
    .link_ready (link_ready)
  );

  cluster_validator validator_i (
    .clk_40            (clk_40),
    .reset             (reset),
    .bx_strobe         (bx_strobe),
    .clusters          (clusters),
    .bxn               (bxn),
    .bc0               (bc0),
    .overflow          (overflow),
    .sample            (sample),
    .sample_strobe     (sample_strobe),
    .valid_clusters    (valid_clusters),
    .valid_clusters_or (valid_clusters_or)
  );

  // ------------------------------
  // Group split and header
  // ------------------------------
  assign payload_right.clusters = sample.clusters[`CLUSTERS_PER_LINK-1:0];
  assign payload_left.clusters  = sample.clusters[`N_CLUSTERS-1:`CLUSTERS_PER_LINK];

  assign header = '{bc0: sample.bc0, overflow: sample.overflow, bxn: sample.bxn[5:0]};

  // ------------------------------
  // Link framers
  // ------------------------------
  // Links 0/1 to CSC, 2/3 to GEM; even links right group, odd links left
  for (genvar i = 0; i < `N_LINKS; i++) begin : g_link
    assign link_payloads[i] = (i % 2 == 0) ? payload_right : payload_left;

    link_framer framer_i (
      .clk_40        (clk_40),
      .reset         (reset),
      .link_ready    (link_ready),
      .sample_strobe (sample_strobe),
      .header        (header),
      .payload       (link_payloads[i]),
      .tx_word       (tx_words[i])
    );

    // Every accepted BX opens a frame on each link in the same cycle
    frame_align_a: assert property (
      @(posedge clk_40) disable iff (reset)
      sample_strobe && link_ready |=>
        !tx_words[i].is_k && tx_words[i].data[15:8] == `COMMA_BYTE
    ) else $error("link %0d did not start its frame with the others", i);
  end

endmodule

//--- design/tx_reset_sequencer.sv
`timescale 1ns/10ps
`include "trigger_link_consts.svh"

module tx_reset_sequencer (
  input  logic clk_40,
  input  logic reset,
  output logic link_ready
);

  localparam logic [3:0] HOLD_END = 4'(`RESET_HOLD_CYCLES);

  logic [3:0] hold_cnt;  // Cycles since reset release

  // ------------------------------
  // Hold counter
  // ------------------------------
  always_ff @(posedge clk_40) begin
    if (reset) begin
      hold_cnt   <= '0;
      link_ready <= 1'b0;
    end else begin
      if (hold_cnt != HOLD_END) begin
        hold_cnt <= hold_cnt + 4'd1;  // Saturates at HOLD_END
      end
      link_ready <= (hold_cnt == HOLD_END);
    end
  end

  // ------------------------------
  // Checks
  // ------------------------------

  // Once released, the links stay up until the next reset
  ready_sticky_a: assert property (
    @(posedge clk_40)
    $fell(link_ready) |-> $past(reset)
  ) else $error("link_ready dropped without reset");

endmodule

//--- tb/link_frame_checker.sv
`timescale 1ns/10ps
`include "trigger_link_consts.svh"

module link_frame_checker
  import trigger_link_pkg::*;
(
  input  logic                       clk_40,
  input  logic                       reset,
  input  cluster_t [`N_CLUSTERS-1:0] clusters,
  input  logic [11:0]                bxn,
  input  logic                       bc0,
  input  logic                       overflow,
  input  logic                       bx_strobe,
  input  logic [`N_CLUSTERS-1:0]     valid_clusters,
  input  logic                       valid_clusters_or,
  input  logic                       link_ready,
  input  link_word_t [`N_LINKS-1:0]  tx_words,
  output int                         error_count,
  output int                         frame_words_seen
);

  int                        low_edges;       // Edges with reset low
  int                        gap;             // Edges since last accepted BX
  int                        widx;            // Expected word index
  logic                      exp_ready;
  logic                      pend;            // Accepted BX, framers start next edge
  logic                      active;
  logic [`N_CLUSTERS-1:0]    exp_valid;
  logic [7:0]                pend_header;
  logic [7:0]                cur_header;
  logic [55:0]               pend_group [2];  // Right group, then left group
  logic [55:0]               cur_group [2];
  logic [7:0]                pend_crc [2];
  logic [7:0]                cur_crc [2];
  link_word_t [`N_LINKS-1:0] exp_words;

  // Byte-wise CRC-8, header byte first
  function automatic logic [7:0] crc_of(input logic [7:0] header, input logic [55:0] group);
    logic [63:0] msg;
    logic [7:0]  crc;
    msg = {header, group};
    crc = 8'h00;
    for (int b = 7; b >= 0; b--) begin
      crc = crc ^ msg[b*8 +: 8];
      for (int k = 0; k < 8; k++) begin
        crc = crc[7] ? ((crc << 1) ^ `CRC8_POLY) : (crc << 1);
      end
    end
    return crc;
  endfunction

  function automatic logic [15:0] frame_word(input int idx, input logic [7:0] header,
                                             input logic [55:0] group, input logic [7:0] crc);
    case (idx)
      0:       return {`COMMA_BYTE, header};
      1:       return group[55:40];
      2:       return group[39:24];
      3:       return group[23:8];
      default: return {group[7:0], crc};
    endcase
  endfunction

  // ------------------------------
  // Reference model
  // ------------------------------
  always @(posedge clk_40) begin : model
    logic take;
    take = bx_strobe && (gap >= `FRAME_WORDS);  // Closer strobes are dropped
    if (reset) begin
      low_edges <= 0;
      gap       <= `FRAME_WORDS;
      exp_ready <= 1'b0;
      exp_valid <= '0;
      pend      <= 1'b0;
      active    <= 1'b0;
      widx      <= 0;
    end else begin
      low_edges <= low_edges + 1;
      exp_ready <= (low_edges + 1 >= `RESET_HOLD_CYCLES + 1);
      gap       <= take ? 1 : gap + 1;
      pend      <= take;
      if (take) begin
        for (int i = 0; i < `N_CLUSTERS; i++) begin
          exp_valid[i] <= !(clusters[i].addr[10] && clusters[i].addr[9]);  // Both set is empty
        end
        pend_header   <= {bc0, overflow, bxn[5:0]};
        pend_group[0] <= clusters[3:0];
        pend_group[1] <= clusters[7:4];
        pend_crc[0]   <= crc_of({bc0, overflow, bxn[5:0]}, clusters[3:0]);
        pend_crc[1]   <= crc_of({bc0, overflow, bxn[5:0]}, clusters[7:4]);
      end
      if (pend && exp_ready) begin
        active     <= 1'b1;
        widx       <= 0;
        cur_header <= pend_header;
        cur_group  <= pend_group;
        cur_crc    <= pend_crc;
      end else if (active) begin
        active <= (widx != `FRAME_WORDS - 1);
        widx   <= (widx == `FRAME_WORDS - 1) ? 0 : widx + 1;
      end
    end
  end

  always_comb begin
    for (int l = 0; l < `N_LINKS; l++) begin
      exp_words[l].data = active ? frame_word(widx, cur_header, cur_group[l % 2], cur_crc[l % 2])
                                 : {`COMMA_BYTE, `IDLE_BYTE};
      exp_words[l].is_k = !active;
    end
  end

  initial begin
    error_count      = 0;
    frame_words_seen = 0;
  end

  always @(posedge clk_40) begin
    if (!reset && !tx_words[0].is_k) begin
      frame_words_seen <= frame_words_seen + 1;
    end
  end

  // ------------------------------
  // Output checks
  // ------------------------------
  ready_a: assert property (@(posedge clk_40) disable iff (reset) link_ready == exp_ready)
    else begin
      error_count++;
      $display("ERROR t=%0t link_ready expected %b actual %b", $time,
               $sampled(exp_ready), $sampled(link_ready));
    end

  valid_a: assert property (@(posedge clk_40) disable iff (reset) valid_clusters == exp_valid)
    else begin
      error_count++;
      $display("ERROR t=%0t valid_clusters expected %b actual %b", $time,
               $sampled(exp_valid), $sampled(valid_clusters));
    end

  valid_or_a: assert property (@(posedge clk_40) disable iff (reset)
                               valid_clusters_or == |exp_valid)
    else begin
      error_count++;
      $display("ERROR t=%0t valid_clusters_or expected %b actual %b", $time,
               $sampled(|exp_valid), $sampled(valid_clusters_or));
    end

  for (genvar l = 0; l < `N_LINKS; l++) begin : g_link
    word_a: assert property (@(posedge clk_40) disable iff (reset) tx_words[l] == exp_words[l])
      else begin
        error_count++;
        $display("ERROR t=%0t tx_words[%0d] expected %h k=%b actual %h k=%b", $time, l,
                 $sampled(exp_words[l].data), $sampled(exp_words[l].is_k),
                 $sampled(tx_words[l].data), $sampled(tx_words[l].is_k));
      end
  end

endmodule

//--- tb/trigger_links_tb.sv
`timescale 1ns/10ps
`include "trigger_link_consts.svh"

module trigger_links_tb
  import trigger_link_pkg::*;
();

  localparam int RESET_CYCLES = 5;
  localparam int TEST_CYCLES  = 35 + 92 + 88 + 128 + 98;  // Tests 1 to 5 with drain
  localparam int CYCLE_LIMIT  = RESET_CYCLES + TEST_CYCLES + 100;

  logic                       clk_40;
  logic                       reset;
  cluster_t [`N_CLUSTERS-1:0] clusters;
  logic [11:0]                bxn;
  logic                       bc0;
  logic                       overflow;
  logic                       bx_strobe;
  logic [`N_CLUSTERS-1:0]     valid_clusters;
  logic                       valid_clusters_or;
  logic                       link_ready;
  link_word_t [`N_LINKS-1:0]  tx_words;

  int chk_errors;       // Assertion failures so far
  int chk_words;        // Frame words seen on link 0
  int cycle_cnt;
  int tests_run;
  int tests_failed;
  int errors_at_start;
  int words_at_start;

  trigger_links dut_i (
    .clk_40            (clk_40),
    .reset             (reset),
    .clusters          (clusters),
    .bxn               (bxn),
    .bc0               (bc0),
    .overflow          (overflow),
    .bx_strobe         (bx_strobe),
    .valid_clusters    (valid_clusters),
    .valid_clusters_or (valid_clusters_or),
    .link_ready        (link_ready),
    .tx_words          (tx_words)
  );

  link_frame_checker checker_i (
    .clk_40            (clk_40),
    .reset             (reset),
    .clusters          (clusters),
    .bxn               (bxn),
    .bc0               (bc0),
    .overflow          (overflow),
    .bx_strobe         (bx_strobe),
    .valid_clusters    (valid_clusters),
    .valid_clusters_or (valid_clusters_or),
    .link_ready        (link_ready),
    .tx_words          (tx_words),
    .error_count       (chk_errors),
    .frame_words_seen  (chk_words)
  );

  initial begin
    clk_40 = 1'b0;
    forever #2 clk_40 = ~clk_40;
  end

  always @(posedge clk_40) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Run stopped after %0d cycles, a test never finished", cycle_cnt);
      $display("Testbench failed");
      $finish;
    end
  end

  // ------------------------------
  // Stimulus helpers
  // ------------------------------
  task automatic next_cycle();
    @(posedge clk_40);
    #0.5;  // Inputs change just after the edge
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic randomize_clusters();
    for (int i = 0; i < `N_CLUSTERS; i++) begin
      clusters[i] = 14'($urandom);
      if ($urandom_range(3) == 0) begin
        clusters[i].addr[10:9] = 2'b11;  // Forced empty slot
      end
    end
  endtask

  task automatic strobe_bx(input int gap);
    bx_strobe = 1'b1;
    next_cycle();
    bx_strobe = 1'b0;
    wait_cycles(gap - 1);
  endtask

  task automatic start_test();
    errors_at_start = chk_errors;
    words_at_start  = chk_words;
  endtask

  task automatic end_test(input string name, input bit want_frames);
    int  errs;
    bit  no_frames;
    wait_cycles(8);  // Last frame drains
    errs      = chk_errors - errors_at_start;
    no_frames = want_frames && (chk_words == words_at_start);
    tests_run++;
    if (no_frames) begin
      tests_failed++;
      $display("%s: FAIL, no frame words appeared on link 0, %0d assertion errors",
               name, errs);
    end else if (errs != 0) begin
      tests_failed++;
      $display("%s: FAIL, %0d assertion errors", name, errs);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    reset        = 1'b1;
    clusters     = '0;
    bxn          = '0;
    bc0          = 1'b0;
    overflow     = 1'b0;
    bx_strobe    = 1'b0;
    cycle_cnt    = 0;
    tests_run    = 0;
    tests_failed = 0;
    void'($urandom(32'h3a9c_ce07));
    repeat (RESET_CYCLES) @(posedge clk_40);
    #0.5;
    reset = 1'b0;

    start_test();
    wait_cycles(3);
    randomize_clusters();
    strobe_bx(24);  // Inside the hold, ready rises meanwhile
    end_test("test 1 reset and hold", 1'b0);

    start_test();
    for (int n = 0; n < 12; n++) begin
      randomize_clusters();
      bxn = bxn + 12'd1;
      strobe_bx(6);
    end
    for (int i = 0; i < `N_CLUSTERS; i++) begin
      clusters[i].addr[10:9] = 2'b11;  // All eight invalid
    end
    strobe_bx(6);
    for (int i = 0; i < `N_CLUSTERS; i++) begin
      clusters[i].addr[10] = 1'b0;
    end
    strobe_bx(6);
    end_test("test 2 validity flags", 1'b1);

    start_test();
    for (int n = 0; n < 10; n++) begin
      randomize_clusters();
      bxn = bxn + 12'd1;
      strobe_bx(8);
    end
    end_test("test 3 frame layout and mapping", 1'b1);

    start_test();
    for (int n = 0; n < 20; n++) begin
      randomize_clusters();
      bxn      = 12'($urandom);
      bc0      = 1'($urandom_range(1));
      overflow = 1'($urandom_range(1));
      strobe_bx(6);
    end
    end_test("test 4 header and CRC", 1'b1);

    start_test();
    for (int n = 0; n < 18; n++) begin
      randomize_clusters();
      bxn = bxn + 12'd1;
      if (n == 12) begin
        strobe_bx(3);
        randomize_clusters();
        strobe_bx(2);  // Too close, dropped
      end else begin
        strobe_bx(`FRAME_WORDS);
      end
    end
    end_test("test 5 back-to-back frames", 1'b1);

    $display("Tests run %0d, failed %0d, assertion errors %0d",
             tests_run, tests_failed, chk_errors);
    if (tests_failed == 0 && chk_errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- trigger_links.f
+incdir+design
design/trigger_link_pkg.sv
design/tx_reset_sequencer.sv
design/cluster_validator.sv
design/link_framer.sv
design/trigger_links.sv
tb/link_frame_checker.sv
tb/trigger_links_tb.sv
